// File: filelist.f
design/dll_tx_pkg.sv
design/fc_limit_regs.sv
design/credit_gate.sv
design/lcrc_engine.sv
design/tx_framer.sv
design/tx_out_reg.sv
design/dll_tx_top.sv
+incdir+tests
tests/tb_dll_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dll transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_dll_tx
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dll_tx 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Finished with no errors$"; then
  exit 0
fi
exit 1

// File: tests/tb_model.svh
// reference model for the dll transmit testbench
// bitwise lcrc, credit class and cost, expected frame words
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// one byte into a reflected crc-32, bit by bit, lsb first
function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] d);
  logic [31:0] c;
  logic fb;
  c = crc;
  for (int b = 0; b < 8; b++) begin
    fb = c[0] ^ d[b];
    c = c >> 1;
    if (fb) begin
      c = c ^ 32'hEDB8_8320;
    end
  end
  return c;
endfunction

// 0 posted, 1 non-posted, 2 completion
function automatic int tlp_class(input logic [7:0] ty);
  case (ty)
    8'h40, 8'h60, 8'h30, 8'h70: return 0;
    8'h0A, 8'h4A: return 2;
    default: return 1;
  endcase
endfunction

function automatic int data_cost(input logic [31:0] dw0);
  int len;
  if (!dw0[6]) begin
    return 0;
  end
  len = {dw0[17:16], dw0[31:24]};
  if (len == 0) begin
    len = 1024;
  end
  return (len + 3) / 4;
endfunction

function automatic void store_word(input logic [31:0] d, input logic [3:0] k, input logic l);
  exp_data[wr_ptr] = d;
  exp_keep[wr_ptr] = k;
  exp_last[wr_ptr] = l;
  wr_ptr = wr_ptr + 1'b1;
endfunction

// out words for one tlp, crc over every byte ahead of it
function automatic void push_frame(input logic [31:0] t[$], input int seq);
  logic [31:0] w;
  logic [31:0] crc;
  logic [15:0] hi;
  crc = 32'hFFFF_FFFF;
  for (int i = 0; i < t.size(); i++) begin
    if (i == 0) begin
      w = {t[0][15:0], 4'h0, seq[11:0]};
    end else begin
      w = {t[i][15:0], t[i-1][31:16]};
    end
    store_word(w, 4'b1111, 1'b0);
    for (int b = 0; b < 4; b++) begin
      crc = crc_add_byte(crc, w[8*b +: 8]);
    end
  end
  hi = t[t.size()-1][31:16];
  crc = crc_add_byte(crc, hi[7:0]);
  crc = crc_add_byte(crc, hi[15:8]);
  crc = ~crc;
  store_word({crc[15:0], hi}, 4'b1111, 1'b0);
  store_word({16'h0, crc[31:16]}, 4'b0011, 1'b1);
endfunction

`endif

// File: tests/tb_dll_tx.sv
// testbench for the dll transmit top
// stimulus tasks, expected word store, assertions, reporting
`timescale 1ns/1ps
`default_nettype none

module tb_dll_tx
  import dll_tx_pkg::*;
();

  localparam int TMO = 2000;

  logic        clk_i;
  logic        rst_i;
  tlp_word_t   s_tlp_i;
  logic        s_valid_i;
  logic        s_ready_o;
  word_t       m_data_o;
  logic [3:0]  m_keep_o;
  logic        m_last_o;
  logic        m_valid_o;
  logic        m_ready_i;
  logic [11:0] seq_num_o;
  logic        dllp_valid_o;
  logic        update_fc_i;
  fc_limits_t  fc_limits_i;

  int seed;
  int errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  int dllp_cnt;
  int frames_sent;
  int seq_exp;
  int used_h[3];
  int used_d[3];
  logic bp_en;
  fc_limits_t pending_lim;

  // expected output words written by the model and read by the collector
  word_t       exp_data[8192];
  logic [3:0]  exp_keep[8192];
  logic        exp_last[8192];
  logic [12:0] rd_ptr;
  logic [12:0] wr_ptr;
  word_t       cur_data;
  logic [3:0]  cur_keep;
  logic        cur_last;

  `include "tb_model.svh"

  assign cur_data = exp_data[rd_ptr];
  assign cur_keep = exp_keep[rd_ptr];
  assign cur_last = exp_last[rd_ptr];

  dll_tx_top #(.SEQ_W(12)) UUT (
    .clk_i(clk_i), .rst_i(rst_i), .s_tlp_i(s_tlp_i), .s_valid_i(s_valid_i),
    .s_ready_o(s_ready_o), .m_data_o(m_data_o), .m_keep_o(m_keep_o),
    .m_last_o(m_last_o), .m_valid_o(m_valid_o), .m_ready_i(m_ready_i),
    .seq_num_o(seq_num_o), .dllp_valid_o(dllp_valid_o),
    .update_fc_i(update_fc_i), .fc_limits_i(fc_limits_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // output collector
  always @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr   <= '0;
      dllp_cnt <= 0;
    end else begin
      if (m_valid_o && m_ready_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (dllp_valid_o) begin
        dllp_cnt <= dllp_cnt + 1;
      end
    end
  end

  always @(posedge clk_i) begin
    if (bp_en) begin
      m_ready_i <= $random(seed) & 1;
    end else begin
      m_ready_i <= 1'b1;
    end
  end

  a_word_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && m_ready_i) |-> (rd_ptr != wr_ptr)) else begin
    errors++;
    $display("output word arrived with no frame expected");
  end
  a_data: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && m_ready_i) |-> (m_data_o == cur_data)) else begin
    errors++;
    $display("[FAIL] m_data_o got %h expected %h", $sampled(m_data_o), $sampled(cur_data));
  end
  a_keep: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && m_ready_i) |-> (m_keep_o == cur_keep)) else begin
    errors++;
    $display("[FAIL] m_keep_o got %h expected %h", $sampled(m_keep_o), $sampled(cur_keep));
  end
  a_last: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && m_ready_i) |-> (m_last_o == cur_last)) else begin
    errors++;
    $display("[FAIL] m_last_o got %h expected %h", $sampled(m_last_o), $sampled(cur_last));
  end
  a_dllp_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    dllp_valid_o |=> !dllp_valid_o) else begin
    errors++;
    $display("dllp_valid_o stayed high for more than one cycle");
  end
  // next sequence number follows the completed frame count
  a_seq: assert property (@(posedge clk_i) disable iff (rst_i)
    seq_num_o == dllp_cnt[11:0]) else begin
    errors++;
    $display("[FAIL] seq_num_o got %h expected %h", $sampled(seq_num_o),
             $sampled(dllp_cnt[11:0]));
  end

  task automatic load_limits(input fc_limits_t l);
    @(posedge clk_i);
    fc_limits_i <= l;
    update_fc_i <= 1'b1;
    @(posedge clk_i);
    update_fc_i <= 1'b0;
  endtask

  // generous headroom in every class
  task automatic open_all();
    fc_limits_t l;
    l.ph   = hdr_cred_t'(used_h[0] + 64);
    l.nph  = hdr_cred_t'(used_h[1] + 64);
    l.cplh = hdr_cred_t'(used_h[2] + 64);
    l.pd   = data_cred_t'(used_d[0] + 1024);
    l.npd  = data_cred_t'(used_d[1] + 1024);
    l.cpld = data_cred_t'(used_d[2] + 1024);
    load_limits(l);
  endtask

  // with hold set the first word must be refused until pending_lim is loaded
  task automatic send_tlp(input logic [7:0] ty, input int len, input bit hold);
    logic [31:0] q[$];
    int n;
    q.push_back({len[7:0], 6'b0, len[9:8], 8'h00, ty});
    q.push_back($random(seed));
    q.push_back($random(seed));
    if (ty[6]) begin
      for (int i = 0; i < len; i++) begin
        q.push_back($random(seed));
      end
    end
    push_frame(q, seq_exp);
    seq_exp++;
    frames_sent++;
    for (int i = 0; i < q.size(); i++) begin
      @(posedge clk_i);
      s_tlp_i.data <= q[i];
      s_tlp_i.last <= (i == q.size() - 1);
      s_valid_i    <= 1'b1;
      if (i == 0 && hold) begin
        repeat (20) begin
          @(negedge clk_i);
          assert (!s_ready_o) else begin
            errors++;
            $display("[FAIL] s_ready_o got %h expected %h", s_ready_o, 1'b0);
          end
        end
        load_limits(pending_lim);
      end
      @(negedge clk_i);
      n = 0;
      while (!s_ready_o && n < TMO) begin
        @(negedge clk_i);
        n++;
      end
      if (n >= TMO) begin
        errors++;
        $display("timeout waiting for s_ready_o to accept a word");
      end
    end
    used_h[tlp_class(ty)] += 1;
    used_d[tlp_class(ty)] += data_cost(q[0]);
    @(posedge clk_i);
    s_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk_i);
    while ((rd_ptr != wr_ptr || dllp_cnt != frames_sent) && n < TMO) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TMO) begin
      errors++;
      $display("timeout waiting for all expected frames to leave the DUT");
    end
    // with every frame out the counter sits on the next number to use
    assert (seq_num_o == seq_exp[11:0]) else begin
      errors++;
      $display("[FAIL] seq_num_o got %h expected %h", seq_num_o, seq_exp[11:0]);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    #2ms;
    $display("simulation watchdog expired");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed = 29926;
    errors = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    frames_sent = 0;
    seq_exp = 0;
    wr_ptr = '0;
    bp_en = 1'b0;
    used_h = '{0, 0, 0};
    used_d = '{0, 0, 0};
    rst_i = 1'b1;
    s_tlp_i = '0;
    s_valid_i = 1'b0;
    m_ready_i = 1'b1;
    update_fc_i = 1'b0;
    fc_limits_i = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (!s_ready_o && !m_valid_o && !dllp_valid_o && seq_num_o == 0) else begin
      errors++;
      $display("outputs not idle after reset");
    end

    // zero limits block a posted write until ph and pd arrive
    pending_lim = '0;
    pending_lim.ph = 8'd1;
    pending_lim.pd = 12'd8;
    send_tlp(8'h40, 2, 1'b1);
    wait_drain();
    end_test("zero credit block");

    // framing across classes
    open_all();
    send_tlp(8'h00, 1 + ($random(seed) & 7), 1'b0);
    send_tlp(8'h44, 1 + ($random(seed) & 7), 1'b0);
    send_tlp(8'h4A, 1 + ($random(seed) & 7), 1'b0);
    wait_drain();
    end_test("framing and lcrc");

    // back-to-back frames with the sequence counted by the model
    open_all();
    for (int i = 0; i < 3; i++) begin
      send_tlp(8'h40, 1 + ($random(seed) & 3), 1'b0);
    end
    wait_drain();
    end_test("sequence numbers");

    // cpld room for exactly one completion
    open_all();
    pending_lim = fc_limits_i;
    pending_lim.cpld = data_cred_t'(used_d[2] + 1);
    load_limits(pending_lim);
    send_tlp(8'h4A, 4, 1'b0);
    pending_lim.cpld = data_cred_t'(used_d[2] + 1);
    send_tlp(8'h4A, 4, 1'b1);
    send_tlp(8'h40, 2, 1'b0);
    wait_drain();
    end_test("credit exhaustion");

    // ph consumed count wraps past 255
    for (int b = 0; b < 3; b++) begin
      pending_lim = fc_limits_i;
      pending_lim.ph = hdr_cred_t'(used_h[0] + 100);
      load_limits(pending_lim);
      for (int i = 0; i < 100; i++) begin
        send_tlp(8'h30, 1, 1'b0);
      end
    end
    pending_lim.ph = hdr_cred_t'(used_h[0]);
    load_limits(pending_lim);
    pending_lim.ph = hdr_cred_t'(used_h[0] + 1);
    send_tlp(8'h30, 1, 1'b1);
    wait_drain();
    end_test("credit wrap");

    // random back-pressure on the output
    bp_en = 1'b1;
    for (int i = 0; i < 10; i++) begin
      open_all();
      case ($random(seed) & 3)
        0: send_tlp(8'h00, 1 + ($random(seed) & 7), 1'b0);
        1: send_tlp(8'h4A, 1 + ($random(seed) & 7), 1'b0);
        default: send_tlp(8'h40, 1 + ($random(seed) & 7), 1'b0);
      endcase
    end
    wait_drain();
    bp_en = 1'b0;
    end_test("output back-pressure");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/dll_tx_top.sv
// data link layer transmit top
// credit gate, framer, lcrc and output register
`timescale 1ns/1ps
`default_nettype none

module dll_tx_top
  import dll_tx_pkg::*;
#(
  parameter int SEQ_W = 12
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  tlp_word_t        s_tlp_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,
  output word_t            m_data_o,
  output logic [3:0]       m_keep_o,
  output logic             m_last_o,
  output logic             m_valid_o,
  input  logic             m_ready_i,
  output logic [SEQ_W-1:0] seq_num_o,
  output logic             dllp_valid_o,
  input  logic             update_fc_i,
  input  fc_limits_t       fc_limits_i
);

  fc_limits_t limits;
  word_t      hdr_dw;
  logic       consume;
  logic       grant;
  crc_t       crc;
  logic       crc_start;
  logic       crc_step;
  logic       crc_half;
  word_t      crc_word;
  out_word_t  frm_word;
  logic       frm_valid;
  logic       frm_ready;
  out_word_t  out_word;

  fc_limit_regs u_limits (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .update_fc_i (update_fc_i),
    .limits_in_i (fc_limits_i),
    .limits_o    (limits)
  );

  credit_gate u_gate (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .limits_i  (limits),
    .hdr_dw_i  (hdr_dw),
    .consume_i (consume),
    .grant_o   (grant)
  );

  lcrc_engine u_lcrc (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (crc_start),
    .step_i  (crc_step),
    .half_i  (crc_half),
    .word_i  (crc_word),
    .crc_o   (crc)
  );

  tx_framer #(
    .SEQ_W (SEQ_W)
  ) u_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_i         (s_tlp_i),
    .in_valid_i   (s_valid_i),
    .in_ready_o   (s_ready_o),
    .hdr_dw_o     (hdr_dw),
    .grant_i      (grant),
    .consume_o    (consume),
    .crc_i        (crc),
    .crc_start_o  (crc_start),
    .crc_step_o   (crc_step),
    .crc_half_o   (crc_half),
    .crc_word_o   (crc_word),
    .out_o        (frm_word),
    .out_valid_o  (frm_valid),
    .out_ready_i  (frm_ready),
    .dllp_valid_o (dllp_valid_o),
    .seq_num_o    (seq_num_o)
  );

  tx_out_reg u_out (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_i        (frm_word),
    .in_valid_i  (frm_valid),
    .in_ready_o  (frm_ready),
    .out_o       (out_word),
    .out_valid_o (m_valid_o),
    .out_ready_i (m_ready_i)
  );

  assign m_data_o = out_word.data;
  assign m_keep_o = out_word.keep;
  assign m_last_o = out_word.last;

endmodule

`default_nettype wire

// File: design/tx_out_reg.sv
// two-entry output skid register
`timescale 1ns/1ps
`default_nettype none

module tx_out_reg
  import dll_tx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  out_word_t in_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output out_word_t out_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  out_word_t skid_q;
  logic      skid_valid_q;
  logic      load_main;

  assign in_ready_o = !skid_valid_q;
  // main slot free or draining this cycle
  assign load_main  = out_ready_i || !out_valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_main) begin
      out_valid_o  <= skid_valid_q || (in_valid_i && in_ready_o);
      skid_valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      out_o <= skid_valid_q ? skid_q : in_i;
    end
    if (!load_main && in_valid_i && in_ready_o) begin
      skid_q <= in_i;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o))
  );

endmodule

`default_nettype wire

// File: design/tx_framer.sv
// tlp framing fsm
// sequence field in front, half-word shift, lcrc trailer
`timescale 1ns/1ps
`default_nettype none

module tx_framer
  import dll_tx_pkg::*;
#(
  parameter int SEQ_W = 12
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  tlp_word_t        in_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  output word_t            hdr_dw_o,
  input  logic             grant_i,
  output logic             consume_o,
  input  crc_t             crc_i,
  output logic             crc_start_o,
  output logic             crc_step_o,
  output logic             crc_half_o,
  output word_t            crc_word_o,
  output out_word_t        out_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             dllp_valid_o,
  output logic [SEQ_W-1:0] seq_num_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_CRC_LO,
    ST_CRC_HI
  } frm_state_e;

  frm_state_e       state_q;
  frm_state_e       state_d;
  logic             fire;
  logic [15:0]      prev_hi_q;
  logic [15:0]      crc_hi_q;
  logic [SEQ_W-1:0] seq_q;

  // credit gate looks at whatever word sits on the input
  assign hdr_dw_o  = in_i.data;
  assign seq_num_o = seq_q;

  always_comb begin
    state_d      = state_q;
    fire         = 1'b0;
    in_ready_o   = 1'b0;
    out_valid_o  = 1'b0;
    out_o.data   = '0;
    out_o.keep   = 4'b1111;
    out_o.last   = 1'b0;
    consume_o    = 1'b0;
    crc_start_o  = 1'b0;
    crc_step_o   = 1'b0;
    crc_half_o   = 1'b0;
    crc_word_o   = '0;
    dllp_valid_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // 4 reserved zero bits sit above the sequence number
        in_ready_o  = grant_i && out_ready_i;
        out_valid_o = in_valid_i && grant_i;
        out_o.data  = {in_i.data[15:0], 16'(seq_q)};
        crc_start_o = 1'b1;
        crc_word_o  = out_o.data;
        fire        = in_valid_i && grant_i && out_ready_i;
        if (fire) begin
          consume_o  = 1'b1;
          crc_step_o = 1'b1;
          state_d    = in_i.last ? ST_CRC_LO : ST_STREAM;
        end
      end
      ST_STREAM: begin
        in_ready_o  = out_ready_i;
        out_valid_o = in_valid_i;
        out_o.data  = {in_i.data[15:0], prev_hi_q};
        crc_word_o  = out_o.data;
        fire        = in_valid_i && out_ready_i;
        crc_step_o  = fire;
        if (fire && in_i.last) begin
          state_d = ST_CRC_LO;
        end
      end
      ST_CRC_LO: begin
        // fold the leftover half and place the crc low half right away
        out_valid_o = 1'b1;
        crc_half_o  = 1'b1;
        crc_word_o  = {prev_hi_q, 16'h0};
        out_o.data  = {crc_i[15:0], prev_hi_q};
        fire        = out_ready_i;
        crc_step_o  = fire;
        if (fire) begin
          state_d = ST_CRC_HI;
        end
      end
      default: begin
        out_valid_o  = 1'b1;
        out_o.data   = {16'h0, crc_hi_q};
        out_o.keep   = 4'b0011;
        out_o.last   = 1'b1;
        fire         = out_ready_i;
        dllp_valid_o = fire;
        if (fire) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      seq_q   <= '0;
    end else begin
      state_q <= state_d;
      // wraps at 2**SEQ_W
      if (dllp_valid_o) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      prev_hi_q <= in_i.data[31:16];
    end
    if (state_q == ST_CRC_LO && fire) begin
      crc_hi_q <= crc_i[31:16];
    end
  end

  // a granted first word stays on offer until the output register takes it
  a_idle_offer_held: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (state_q == ST_IDLE && out_valid_o && !out_ready_i) |=> out_valid_o
  );

endmodule

`default_nettype wire

// File: design/lcrc_engine.sv
// running lcrc, reflected crc-32
// folds a whole word or its upper half per step
`timescale 1ns/1ps
`default_nettype none

module lcrc_engine
  import dll_tx_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  start_i,
  input  logic  step_i,
  input  logic  half_i,
  input  word_t word_i,
  output crc_t  crc_o
);

  crc_t crc_q;
  crc_t seed;
  crc_t crc_lo;
  crc_t crc_next;

  // one byte, lsb first
  function automatic crc_t crc_byte(input crc_t crc, input logic [7:0] data);
    crc_t c;
    c = crc ^ {24'h0, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ LCRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  assign seed = start_i ? LCRC_INIT : crc_q;

  // half step skips the two low bytes
  assign crc_lo   = half_i ? seed : crc_byte(crc_byte(seed, word_i[7:0]), word_i[15:8]);
  assign crc_next = crc_byte(crc_byte(crc_lo, word_i[23:16]), word_i[31:24]);

  // final value including the present word
  assign crc_o = ~crc_next;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= LCRC_INIT;
    end else if (step_i) begin
      crc_q <= crc_next;
    end
  end

endmodule

`default_nettype wire

// File: design/credit_gate.sv
// flow control credit gate
// classifies tlp dword 0, keeps consumed counters, grants on headroom
`timescale 1ns/1ps
`default_nettype none

module credit_gate
  import dll_tx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  fc_limits_t limits_i,
  input  word_t      hdr_dw_i,
  input  logic       consume_i,
  output logic       grant_o
);

  logic [7:0]  fmt_type;
  logic [9:0]  len_field;
  logic [10:0] len_dw;
  data_cred_t  d_cost;
  cred_class_e cls;
  hdr_cred_t   hdr_room;
  data_cred_t  data_room;

  hdr_cred_t  ph_used_q;
  hdr_cred_t  nph_used_q;
  hdr_cred_t  cplh_used_q;
  data_cred_t pd_used_q;
  data_cred_t npd_used_q;
  data_cred_t cpld_used_q;

  assign fmt_type  = hdr_dw_i[7:0];
  assign len_field = {hdr_dw_i[17:16], hdr_dw_i[31:24]};
  // length 0 encodes 1024 dwords
  assign len_dw    = {len_field == 10'd0, len_field};

  // one data credit per 4 dwords, rounded up
  always_comb begin
    d_cost = '0;
    if (fmt_type[6]) begin
      d_cost = ({1'b0, len_dw} + 12'd3) >> 2;
    end
  end

  always_comb begin
    if (fmt_type inside {TLP_MWR32, TLP_MWR64, TLP_MSG, TLP_MSGD}) begin
      cls = CLASS_P;
    end else if (fmt_type inside {TLP_CPL, TLP_CPLD}) begin
      cls = CLASS_CPL;
    end else begin
      // np types and anything unknown
      cls = CLASS_NP;
    end
  end

  // headroom wraps with the field width
  always_comb begin
    case (cls)
      CLASS_P: begin
        hdr_room  = limits_i.ph - ph_used_q;
        data_room = limits_i.pd - pd_used_q;
      end
      CLASS_CPL: begin
        hdr_room  = limits_i.cplh - cplh_used_q;
        data_room = limits_i.cpld - cpld_used_q;
      end
      default: begin
        hdr_room  = limits_i.nph - nph_used_q;
        data_room = limits_i.npd - npd_used_q;
      end
    endcase
  end

  // header cost is always one
  assign grant_o = (hdr_room != '0) && (d_cost <= data_room);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_used_q   <= '0;
      nph_used_q  <= '0;
      cplh_used_q <= '0;
      pd_used_q   <= '0;
      npd_used_q  <= '0;
      cpld_used_q <= '0;
    end else if (consume_i) begin
      case (cls)
        CLASS_P: begin
          ph_used_q <= ph_used_q + hdr_cred_t'(1);
          pd_used_q <= pd_used_q + d_cost;
        end
        CLASS_CPL: begin
          cplh_used_q <= cplh_used_q + hdr_cred_t'(1);
          cpld_used_q <= cpld_used_q + d_cost;
        end
        default: begin
          nph_used_q <= nph_used_q + hdr_cred_t'(1);
          npd_used_q <= npd_used_q + d_cost;
        end
      endcase
    end
  end

  // the framer must only take a tlp this gate has cleared
  a_consume_granted: assert property (
    @(posedge clk_i) disable iff (rst_i)
    consume_i |-> grant_o
  );

endmodule

`default_nettype wire

// File: design/fc_limit_regs.sv
// credit limit registers
// loaded from the link partner's flow control update
`timescale 1ns/1ps
`default_nettype none

module fc_limit_regs
  import dll_tx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       update_fc_i,
  input  fc_limits_t limits_in_i,
  output fc_limits_t limits_o
);

  // zero limits after reset, so nothing goes out before the first update
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      limits_o.ph   <= '0;
      limits_o.nph  <= '0;
      limits_o.cplh <= '0;
      limits_o.pd   <= '0;
      limits_o.npd  <= '0;
      limits_o.cpld <= '0;
    end else if (update_fc_i) begin
      limits_o.ph   <= limits_in_i.ph;
      limits_o.nph  <= limits_in_i.nph;
      limits_o.cplh <= limits_in_i.cplh;
      limits_o.pd   <= limits_in_i.pd;
      limits_o.npd  <= limits_in_i.npd;
      limits_o.cpld <= limits_in_i.cpld;
    end
  end

  // an update with x bits would poison every later grant decision
  a_update_known: assert property (
    @(posedge clk_i) disable iff (rst_i)
    update_fc_i |-> !$isunknown(limits_in_i)
  );

endmodule

`default_nettype wire

// File: design/dll_tx_pkg.sv
// shared widths and vector types for the dll transmit path
// tlp fmt/type codes, credit classes
// stream word and credit limit structs
`default_nettype none

package dll_tx_pkg;

  localparam int WORD_W      = 32;
  localparam int HDR_CRED_W  = 8;
  localparam int DATA_CRED_W = 12;
  localparam int CRC_W       = 32;

  // reflected crc-32, as used for the lcrc
  localparam logic [CRC_W-1:0] LCRC_POLY = 32'hEDB8_8320;
  localparam logic [CRC_W-1:0] LCRC_INIT = 32'hFFFF_FFFF;

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [HDR_CRED_W-1:0]  hdr_cred_t;
  typedef logic [DATA_CRED_W-1:0] data_cred_t;
  typedef logic [CRC_W-1:0]       crc_t;

  // fmt/type byte of tlp dword 0, bit 6 set means the tlp has data
  typedef enum logic [7:0] {
    TLP_MRD32  = 8'h00,
    TLP_MRD64  = 8'h20,
    TLP_IORD   = 8'h02,
    TLP_IOWR   = 8'h42,
    TLP_CFGRD0 = 8'h04,
    TLP_CFGWR0 = 8'h44,
    TLP_MWR32  = 8'h40,
    TLP_MWR64  = 8'h60,
    TLP_MSG    = 8'h30,
    TLP_MSGD   = 8'h70,
    TLP_CPL    = 8'h0A,
    TLP_CPLD   = 8'h4A
  } tlp_type_e;

  typedef enum logic [1:0] {
    CLASS_P,
    CLASS_NP,
    CLASS_CPL
  } cred_class_e;

  typedef struct packed {
    word_t data;
    logic  last;
  } tlp_word_t;

  // advertised limits from the link partner
  typedef struct packed {
    hdr_cred_t  ph;
    hdr_cred_t  nph;
    hdr_cred_t  cplh;
    data_cred_t pd;
    data_cred_t npd;
    data_cred_t cpld;
  } fc_limits_t;

  typedef struct packed {
    word_t      data;
    logic [3:0] keep;
    logic       last;
  } out_word_t;

endpackage

`default_nettype wire
